/* rtl/prof_consts.svh */
// Mesh size, request widths and the print-stat address for the
// tile profiling subsystem.
`ifndef PROF_CONSTS_SVH
`define PROF_CONSTS_SVH

// Mesh geometry.
`define PROF_NUM_X            2
`define PROF_NUM_Y            2
`define PROF_NUM_TILES        (`PROF_NUM_X * `PROF_NUM_Y)

// Remote request fields.
`define PROF_ADDR_WIDTH       32
`define PROF_DATA_WIDTH       32

// Store to this address carries a print tag in its payload.
`define PROF_PRINT_STAT_ADDR  32'h0000_1D0C

// Coordinate and tile index widths.
`define PROF_X_WIDTH          1
`define PROF_Y_WIDTH          1
`define PROF_TILE_WIDTH       2

`endif

/* rtl/prof_pkg.sv */
// Shared width types for the profiling subsystem.
`default_nettype none

`include "prof_consts.svh"

package prof_pkg;

  // ------------------------------------------------------------------------
  // Mesh addressing
  // ------------------------------------------------------------------------
  typedef logic [`PROF_TILE_WIDTH-1:0] tile_id_t;  // Index of one tile.
  typedef logic [`PROF_X_WIDTH-1:0]    cord_x_t;   // Column in the mesh.
  typedef logic [`PROF_Y_WIDTH-1:0]    cord_y_t;   // Row in the mesh.

  // ------------------------------------------------------------------------
  // Profiling payloads
  // ------------------------------------------------------------------------
  // The tag is the payload of the print-stat store.
  typedef logic [`PROF_DATA_WIDTH-1:0] prof_tag_t;

  // Cycle, instruction and drop counts.
  typedef logic [31:0]                 prof_ctr_t;

endpackage

`default_nettype wire

/* rtl/prof_req_decoder.sv */
// Global cycle counter and per-tile detection of print-stat stores.
`timescale 1ns/1ps
`default_nettype none

`include "prof_consts.svh"

module prof_req_decoder
  import prof_pkg::*;
(
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  input  logic                                        global_ctr_clear_i,
  input  logic [`PROF_NUM_TILES-1:0]                  req_v_i,
  input  logic [`PROF_NUM_TILES-1:0]                  req_yumi_i,
  input  logic [`PROF_NUM_TILES*`PROF_ADDR_WIDTH-1:0] req_addr_i,
  input  logic [`PROF_NUM_TILES*`PROF_DATA_WIDTH-1:0] req_payload_i,
  output logic [`PROF_NUM_TILES-1:0]                  print_v_o,
  output prof_tag_t [`PROF_NUM_TILES-1:0]             print_tag_o,
  output prof_ctr_t                                   global_ctr_o
);

  logic [`PROF_NUM_TILES-1:0]      fire;
  logic [`PROF_NUM_TILES-1:0]      print_v_r;
  prof_tag_t [`PROF_NUM_TILES-1:0] print_tag_r;
  prof_ctr_t                       global_ctr_r;

  // ------------------------------------------------------------------------
  // Global cycle counter
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i || global_ctr_clear_i) begin
      global_ctr_r <= '0;
    end else begin
      global_ctr_r <= global_ctr_r + 32'd1;
    end
  end

  // ------------------------------------------------------------------------
  // Print-stat detection
  // ------------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < `PROF_NUM_TILES; i++) begin
      fire[i] = req_v_i[i] & req_yumi_i[i]  // Accepted by the network.
        & (req_addr_i[i*`PROF_ADDR_WIDTH +: `PROF_ADDR_WIDTH] == `PROF_PRINT_STAT_ADDR);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      print_v_r <= '0;
    end else begin
      print_v_r <= fire;  // One-cycle strobe per accepted store.
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < `PROF_NUM_TILES; i++) begin
      if (fire[i]) begin
        print_tag_r[i] <= req_payload_i[i*`PROF_DATA_WIDTH +: `PROF_DATA_WIDTH];
      end
    end
  end

  assign print_v_o    = print_v_r;
  assign print_tag_o  = print_tag_r;
  assign global_ctr_o = global_ctr_r;

endmodule

`default_nettype wire

/* rtl/tile_profiler.sv */
// Per-tile cycle and commit counters, stall-gated print tag pipeline
// and the pending snapshot record.
`timescale 1ns/1ps
`default_nettype none

`include "prof_consts.svh"

module tile_profiler
  import prof_pkg::*;
#(
  parameter int TILE_ID = 0
) (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        stall_i,
  input  logic        stall_depend_i,
  input  logic        flush_i,
  input  logic [31:0] id_instr_i,
  input  logic        id_icache_miss_i,
  input  logic        print_v_i,
  input  prof_tag_t   print_tag_i,
  input  prof_ctr_t   global_ctr_i,
  input  logic        ack_i,
  output logic        pend_o,
  output cord_x_t     rec_x_o,
  output cord_y_t     rec_y_o,
  output prof_tag_t   rec_tag_o,
  output prof_ctr_t   rec_global_ctr_o,
  output prof_ctr_t   rec_total_cycle_o,
  output prof_ctr_t   rec_instr_o,
  output prof_ctr_t   rec_dropped_o
);

  localparam cord_x_t MY_X = cord_x_t'(TILE_ID % `PROF_NUM_X);
  localparam cord_y_t MY_Y = cord_y_t'(TILE_ID / `PROF_NUM_X);

  logic      instr_committed;
  prof_ctr_t total_cycle_r;
  prof_ctr_t instr_r;

  logic      exe_v;
  logic      exe_r;
  logic      mem_r;
  logic      wb_r;
  prof_tag_t exe_tag;
  prof_tag_t exe_tag_r;
  prof_tag_t mem_tag_r;
  prof_tag_t wb_tag_r;
  logic      print_now;

  logic      pend_r;
  prof_tag_t hold_tag_r;
  prof_ctr_t hold_global_ctr_r;
  prof_ctr_t hold_total_cycle_r;
  prof_ctr_t hold_instr_r;
  prof_ctr_t dropped_r;

  // ------------------------------------------------------------------------
  // Counters
  // ------------------------------------------------------------------------
  assign instr_committed = ~stall_i & ~stall_depend_i & ~flush_i
    & (id_instr_i != 32'd0) & ~id_icache_miss_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      total_cycle_r <= '0;
      instr_r       <= '0;
    end else begin
      total_cycle_r <= total_cycle_r + 32'd1;
      if (instr_committed) begin
        instr_r <= instr_r + 32'd1;
      end
    end
  end

  // ------------------------------------------------------------------------
  // Tag pipeline, exe to mem to wb
  // ------------------------------------------------------------------------
  // The strobe itself is the exe stage; exe_r keeps it across stalls.
  assign exe_v   = print_v_i | exe_r;
  assign exe_tag = print_v_i ? print_tag_i : exe_tag_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exe_r <= 1'b0;
      mem_r <= 1'b0;
      wb_r  <= 1'b0;
    end else begin
      exe_r <= exe_v & stall_i;
      if (!stall_i) begin
        mem_r <= exe_v;
        wb_r  <= mem_r;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (print_v_i) exe_tag_r <= print_tag_i;
    if (!stall_i && exe_v) mem_tag_r <= exe_tag;
    if (!stall_i && mem_r) wb_tag_r <= mem_tag_r;
  end

  assign print_now = wb_r & ~stall_i;

  // ------------------------------------------------------------------------
  // Holding register
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pend_r    <= 1'b0;
      dropped_r <= '0;
    end else if (print_now) begin
      pend_r <= 1'b1;
      if (pend_r && !ack_i) begin
        dropped_r <= dropped_r + 32'd1;  // Unread record is overwritten.
      end else begin
        dropped_r <= '0;
      end
    end else if (ack_i) begin
      pend_r    <= 1'b0;
      dropped_r <= '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (print_now) begin
      hold_tag_r         <= wb_tag_r;
      hold_global_ctr_r  <= global_ctr_i;
      hold_total_cycle_r <= total_cycle_r;  // Before this cycle's increment.
      hold_instr_r       <= instr_r;
    end
  end

  assign pend_o            = pend_r;
  assign rec_x_o           = MY_X;
  assign rec_y_o           = MY_Y;
  assign rec_tag_o         = hold_tag_r;
  assign rec_global_ctr_o  = hold_global_ctr_r;
  assign rec_total_cycle_o = hold_total_cycle_r;
  assign rec_instr_o       = hold_instr_r;
  assign rec_dropped_o     = dropped_r;

endmodule

`default_nettype wire

/* rtl/prof_stat_collector.sv */
// Round-robin choice among tiles with pending records and the
// registered valid/yumi record output.
`timescale 1ns/1ps
`default_nettype none

`include "prof_consts.svh"

module prof_stat_collector
  import prof_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic [`PROF_NUM_TILES-1:0]      pend_i,
  input  cord_x_t [`PROF_NUM_TILES-1:0]   x_i,
  input  cord_y_t [`PROF_NUM_TILES-1:0]   y_i,
  input  prof_tag_t [`PROF_NUM_TILES-1:0] tag_i,
  input  prof_ctr_t [`PROF_NUM_TILES-1:0] global_ctr_i,
  input  prof_ctr_t [`PROF_NUM_TILES-1:0] total_cycle_i,
  input  prof_ctr_t [`PROF_NUM_TILES-1:0] instr_i,
  input  prof_ctr_t [`PROF_NUM_TILES-1:0] dropped_i,
  output logic [`PROF_NUM_TILES-1:0]      ack_o,
  output logic                            rec_v_o,
  input  logic                            rec_yumi_i,
  output cord_x_t                         rec_x_o,
  output cord_y_t                         rec_y_o,
  output prof_tag_t                       rec_tag_o,
  output prof_ctr_t                       rec_global_ctr_o,
  output prof_ctr_t                       rec_total_cycle_o,
  output prof_ctr_t                       rec_instr_o,
  output prof_ctr_t                       rec_dropped_o
);

  logic [`PROF_NUM_TILES-1:0] cand;
  logic                       pick_v;
  tile_id_t                   pick;
  logic                       load;
  logic                       rec_v_r;
  tile_id_t                   sel_r;  // Tile on the output, also the RR pointer.

  // ------------------------------------------------------------------------
  // Round-robin arbiter
  // ------------------------------------------------------------------------
  always_comb begin
    ack_o        = '0;
    ack_o[sel_r] = rec_v_r & rec_yumi_i;
  end

  // The tile being acked still shows pend_i this cycle.
  assign cand = pend_i & ~ack_o;

  always_comb begin
    int idx;
    pick_v = 1'b0;
    pick   = '0;
    for (int k = `PROF_NUM_TILES - 1; k >= 0; k--) begin
      idx = (int'(sel_r) + 1 + k) % `PROF_NUM_TILES;
      if (cand[idx]) begin  // Smallest distance from sel_r wins.
        pick_v = 1'b1;
        pick   = tile_id_t'(idx);
      end
    end
  end

  assign load = (~rec_v_r | rec_yumi_i) & pick_v;

  // ------------------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rec_v_r <= 1'b0;
      sel_r   <= tile_id_t'(`PROF_NUM_TILES - 1);  // Tile 0 goes first.
    end else if (load) begin
      rec_v_r <= 1'b1;
      sel_r   <= pick;
    end else if (rec_yumi_i) begin
      rec_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      rec_x_o           <= x_i[pick];
      rec_y_o           <= y_i[pick];
      rec_tag_o         <= tag_i[pick];
      rec_global_ctr_o  <= global_ctr_i[pick];
      rec_total_cycle_o <= total_cycle_i[pick];
      rec_instr_o       <= instr_i[pick];
      rec_dropped_o     <= dropped_i[pick];
    end
  end

  assign rec_v_o = rec_v_r;

endmodule

`default_nettype wire

/* rtl/prof_top.sv */
// Profiling subsystem top: request decoder, one profiler per tile and
// the record collector.
`timescale 1ns/1ps
`default_nettype none

`include "prof_consts.svh"

module prof_top
  import prof_pkg::*;
(
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  input  logic                                        global_ctr_clear_i,
  input  logic [`PROF_NUM_TILES-1:0]                  stall_i,
  input  logic [`PROF_NUM_TILES-1:0]                  stall_depend_i,
  input  logic [`PROF_NUM_TILES-1:0]                  flush_i,
  input  logic [`PROF_NUM_TILES*32-1:0]               id_instr_i,
  input  logic [`PROF_NUM_TILES-1:0]                  id_icache_miss_i,
  input  logic [`PROF_NUM_TILES-1:0]                  req_v_i,
  input  logic [`PROF_NUM_TILES-1:0]                  req_yumi_i,
  input  logic [`PROF_NUM_TILES*`PROF_ADDR_WIDTH-1:0] req_addr_i,
  input  logic [`PROF_NUM_TILES*`PROF_DATA_WIDTH-1:0] req_payload_i,
  output logic                                        rec_v_o,
  input  logic                                        rec_yumi_i,
  output cord_x_t                                     rec_x_o,
  output cord_y_t                                     rec_y_o,
  output prof_tag_t                                   rec_tag_o,
  output prof_ctr_t                                   rec_global_ctr_o,
  output prof_ctr_t                                   rec_total_cycle_o,
  output prof_ctr_t                                   rec_instr_o,
  output prof_ctr_t                                   rec_dropped_o
);

  logic [`PROF_NUM_TILES-1:0]      print_v;
  prof_tag_t [`PROF_NUM_TILES-1:0] print_tag;
  prof_ctr_t                       global_ctr;

  logic [`PROF_NUM_TILES-1:0]      pend;
  logic [`PROF_NUM_TILES-1:0]      ack;
  cord_x_t [`PROF_NUM_TILES-1:0]   tile_x;
  cord_y_t [`PROF_NUM_TILES-1:0]   tile_y;
  prof_tag_t [`PROF_NUM_TILES-1:0] tile_tag;
  prof_ctr_t [`PROF_NUM_TILES-1:0] tile_global_ctr;
  prof_ctr_t [`PROF_NUM_TILES-1:0] tile_total_cycle;
  prof_ctr_t [`PROF_NUM_TILES-1:0] tile_instr;
  prof_ctr_t [`PROF_NUM_TILES-1:0] tile_dropped;

  prof_req_decoder u_decoder (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .global_ctr_clear_i (global_ctr_clear_i),
    .req_v_i            (req_v_i),
    .req_yumi_i         (req_yumi_i),
    .req_addr_i         (req_addr_i),
    .req_payload_i      (req_payload_i),
    .print_v_o          (print_v),
    .print_tag_o        (print_tag),
    .global_ctr_o       (global_ctr)
  );

  // ------------------------------------------------------------------------
  // One profiler per tile
  // ------------------------------------------------------------------------
  for (genvar i = 0; i < `PROF_NUM_TILES; i++) begin : g_tile
    tile_profiler #(.TILE_ID(i)) u_tile (
      .clk_i             (clk_i),
      .reset_i           (reset_i),
      .stall_i           (stall_i[i]),
      .stall_depend_i    (stall_depend_i[i]),
      .flush_i           (flush_i[i]),
      .id_instr_i        (id_instr_i[i*32 +: 32]),
      .id_icache_miss_i  (id_icache_miss_i[i]),
      .print_v_i         (print_v[i]),
      .print_tag_i       (print_tag[i]),
      .global_ctr_i      (global_ctr),
      .ack_i             (ack[i]),
      .pend_o            (pend[i]),
      .rec_x_o           (tile_x[i]),
      .rec_y_o           (tile_y[i]),
      .rec_tag_o         (tile_tag[i]),
      .rec_global_ctr_o  (tile_global_ctr[i]),
      .rec_total_cycle_o (tile_total_cycle[i]),
      .rec_instr_o       (tile_instr[i]),
      .rec_dropped_o     (tile_dropped[i])
    );
  end

  prof_stat_collector u_collector (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .pend_i            (pend),
    .x_i               (tile_x),
    .y_i               (tile_y),
    .tag_i             (tile_tag),
    .global_ctr_i      (tile_global_ctr),
    .total_cycle_i     (tile_total_cycle),
    .instr_i           (tile_instr),
    .dropped_i         (tile_dropped),
    .ack_o             (ack),
    .rec_v_o           (rec_v_o),
    .rec_yumi_i        (rec_yumi_i),
    .rec_x_o           (rec_x_o),
    .rec_y_o           (rec_y_o),
    .rec_tag_o         (rec_tag_o),
    .rec_global_ctr_o  (rec_global_ctr_o),
    .rec_total_cycle_o (rec_total_cycle_o),
    .rec_instr_o       (rec_instr_o),
    .rec_dropped_o     (rec_dropped_o)
  );

endmodule

`default_nettype wire

/* dv/prof_tb.sv */
// Testbench for the profiling subsystem with a cycle model of the
// profiling rules and checks on the record stream.
`timescale 1ns/1ps
`default_nettype none

`include "prof_consts.svh"

module prof_tb
  import prof_pkg::*;
();

  localparam int NT         = `PROF_NUM_TILES;
  localparam int MAX_CYCLES = 2000;  // Five tests take roughly 300 cycles.

  logic                                clk_i;
  logic                                reset_i;
  logic                                global_ctr_clear_i;
  logic [NT-1:0]                       stall_i;
  logic [NT-1:0]                       stall_depend_i;
  logic [NT-1:0]                       flush_i;
  logic [NT*32-1:0]                    id_instr_i;
  logic [NT-1:0]                       id_icache_miss_i;
  logic [NT-1:0]                       req_v_i;
  logic [NT-1:0]                       req_yumi_i;
  logic [NT*`PROF_ADDR_WIDTH-1:0]      req_addr_i;
  logic [NT*`PROF_DATA_WIDTH-1:0]      req_payload_i;
  logic                                rec_v_o;
  logic                                rec_yumi_i;
  cord_x_t                             rec_x_o;
  cord_y_t                             rec_y_o;
  prof_tag_t                           rec_tag_o;
  prof_ctr_t                           rec_global_ctr_o;
  prof_ctr_t                           rec_total_cycle_o;
  prof_ctr_t                           rec_instr_o;
  prof_ctr_t                           rec_dropped_o;

  int unsigned stall_pct [NT];
  int unsigned yumi_pct;
  int          errors;
  int          tests_failed;
  int          cycle;

  // Model of the counters, the tag pipeline and the pending records.
  prof_ctr_t   m_global;
  prof_ctr_t   m_total [NT];
  prof_ctr_t   m_instr [NT];
  logic        m_fly [NT];
  int          m_stage [NT];
  prof_tag_t   m_fly_tag [NT];
  int          m_stalls [NT];
  logic        m_pend [NT];
  prof_tag_t   m_tag [NT];
  prof_ctr_t   m_gc [NT];
  prof_ctr_t   m_tc [NT];
  prof_ctr_t   m_ic [NT];
  prof_ctr_t   m_drop [NT];
  logic        m_out_v;
  int          m_out_tile;
  int          m_last;
  prof_tag_t   m_out_tag;
  prof_ctr_t   m_out_gc;
  prof_ctr_t   m_out_tc;
  prof_ctr_t   m_out_ic;
  prof_ctr_t   m_out_drop;

  // Record on the output as seen at the last falling edge.
  logic        shown_v;
  int          shown_tile;
  prof_tag_t   shown_tag;
  prof_ctr_t   shown_gc;
  prof_ctr_t   shown_drop;
  int          taken_q [$];
  prof_tag_t   taken_tag;
  prof_ctr_t   taken_gc;
  prof_ctr_t   taken_drop;

  prof_top u_prof_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  a_rec_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    rec_v_o && !rec_yumi_i |=> rec_v_o && $stable(rec_x_o) && $stable(rec_y_o)
      && $stable(rec_tag_o) && $stable(rec_global_ctr_o) && $stable(rec_total_cycle_o)
      && $stable(rec_instr_o) && $stable(rec_dropped_o))
  else begin
    $display("Record changed or vanished while it waited for yumi");
    errors++;
  end

  always @(negedge clk_i) begin
    shown_v = 1'b0;
    if (!reset_i) begin
      check("rec_v_o", 32'(rec_v_o), 32'(m_out_v));
      if (m_out_v) begin
        check("rec_x_o", 32'(rec_x_o), 32'(m_out_tile % `PROF_NUM_X));
        check("rec_y_o", 32'(rec_y_o), 32'(m_out_tile / `PROF_NUM_X));
        check("rec_tag_o", rec_tag_o, m_out_tag);
        check("rec_global_ctr_o", rec_global_ctr_o, m_out_gc);
        check("rec_total_cycle_o", rec_total_cycle_o, m_out_tc);
        check("rec_instr_o", rec_instr_o, m_out_ic);
        check("rec_dropped_o", rec_dropped_o, m_out_drop);
      end
      shown_v    = rec_v_o;
      shown_tile = int'(rec_x_o) + int'(rec_y_o) * `PROF_NUM_X;
      shown_tag  = rec_tag_o;
      shown_gc   = rec_global_ctr_o;
      shown_drop = rec_dropped_o;
    end
  end

  // --------------------------------------------------------------------------
  // Reference model stepped on each rising edge
  // --------------------------------------------------------------------------
  always @(posedge clk_i) begin
    int            pick;
    logic [NT-1:0] acked;
    if (reset_i) begin
      m_global = '0;
      m_out_v  = 1'b0;
      m_last   = NT - 1;
      for (int i = 0; i < NT; i++) begin
        m_total[i] = '0;
        m_instr[i] = '0;
        m_fly[i]   = 1'b0;
        m_pend[i]  = 1'b0;
        m_drop[i]  = '0;
      end
    end else begin
      acked = '0;
      if (m_out_v && rec_yumi_i) acked[m_out_tile] = 1'b1;
      if (shown_v && rec_yumi_i) begin
        taken_q.push_back(shown_tile);
        taken_tag  = shown_tag;
        taken_gc   = shown_gc;
        taken_drop = shown_drop;
      end
      pick = -1;
      for (int k = 1; k <= NT; k++) begin
        if (pick < 0 && m_pend[(m_last + k) % NT] && !acked[(m_last + k) % NT])
          pick = (m_last + k) % NT;
      end
      if ((!m_out_v || rec_yumi_i) && pick >= 0) begin
        m_out_v    = 1'b1;
        m_out_tile = pick;
        m_last     = pick;
        m_out_tag  = m_tag[pick];
        m_out_gc   = m_gc[pick];
        m_out_tc   = m_tc[pick];
        m_out_ic   = m_ic[pick];
        m_out_drop = m_drop[pick];
      end else if (rec_yumi_i) begin
        m_out_v = 1'b0;
      end
      for (int i = 0; i < NT; i++) begin
        if (acked[i]) begin
          m_pend[i] = 1'b0;
          m_drop[i] = '0;
        end
        if (m_fly[i]) begin
          if (stall_i[i]) begin
            m_stalls[i]++;
          end else if (m_stage[i] == 2) begin  // Writeback takes the snapshot.
            m_drop[i] = m_pend[i] ? m_drop[i] + 32'd1 : '0;
            m_pend[i] = 1'b1;
            m_tag[i]  = m_fly_tag[i];
            m_gc[i]   = m_global;
            m_tc[i]   = m_total[i];
            m_ic[i]   = m_instr[i];
            m_fly[i]  = 1'b0;
          end else begin
            m_stage[i]++;
          end
        end
        if (req_v_i[i] && req_yumi_i[i]
            && req_addr_i[i*`PROF_ADDR_WIDTH +: `PROF_ADDR_WIDTH] == `PROF_PRINT_STAT_ADDR) begin
          m_fly[i]     = 1'b1;
          m_stage[i]   = 0;
          m_stalls[i]  = 0;
          m_fly_tag[i] = req_payload_i[i*`PROF_DATA_WIDTH +: `PROF_DATA_WIDTH];
        end
        if (!stall_i[i] && !stall_depend_i[i] && !flush_i[i] && !id_icache_miss_i[i]
            && id_instr_i[i*32 +: 32] != 32'd0)
          m_instr[i] = m_instr[i] + 32'd1;
        m_total[i] = m_total[i] + 32'd1;
      end
      m_global = global_ctr_clear_i ? '0 : m_global + 32'd1;
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  always @(negedge clk_i) begin
    for (int i = 0; i < NT; i++) begin
      stall_i[i]               = ($urandom % 100) < stall_pct[i];
      stall_depend_i[i]        = ($urandom % 4) == 0;
      flush_i[i]               = ($urandom % 8) == 0;
      id_icache_miss_i[i]      = ($urandom % 8) == 0;
      id_instr_i[i*32 +: 32]   = (($urandom % 4) == 0) ? 32'd0 : $urandom;
    end
    rec_yumi_i = rec_v_o && (($urandom % 100) < yumi_pct);
  end

  task automatic drive_req(input logic [NT-1:0] mask, input logic [31:0] addr,
                           input prof_tag_t tag, input logic [NT-1:0] yumi);
    @(negedge clk_i);
    for (int i = 0; i < NT; i++) begin
      req_v_i[i]                                          = mask[i];
      req_yumi_i[i]                                       = yumi[i];
      req_addr_i[i*`PROF_ADDR_WIDTH +: `PROF_ADDR_WIDTH]  = addr;
      req_payload_i[i*`PROF_DATA_WIDTH +: `PROF_DATA_WIDTH] = tag + 32'(i);
    end
    @(negedge clk_i);
    req_v_i    = '0;
    req_yumi_i = '0;
  endtask

  // Fires one print and counts falling edges until the record shows up.
  task automatic measure_print(input int tile, input prof_tag_t tag, output int lat);
    drive_req(NT'(1 << tile), `PROF_PRINT_STAT_ADDR, tag, '1);
    lat = 1;
    while (!rec_v_o && lat < 200) begin
      @(negedge clk_i);
      lat++;
    end
    if (!rec_v_o) begin
      $display("No record arrived for the print to tile %0d", tile);
      errors++;
    end
  endtask

  function automatic logic model_busy();
    logic b;
    b = 1'b0;
    for (int i = 0; i < NT; i++) b = b | m_pend[i] | m_fly[i];
    return b;
  endfunction

  task automatic wait_drain();
    int n;
    n = 0;
    while ((rec_v_o || model_busy()) && n < 300) begin
      @(negedge clk_i);
      n++;
    end
    if (n >= 300) begin
      $display("Records did not drain from the output");
      errors++;
    end
  endtask

  task automatic end_test(input int num, input string name, input int err_before);
    if (errors == err_before) begin
      $display("test %0d %s: passed", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, errors - err_before);
      tests_failed++;
    end
  endtask

  task automatic set_stall(input int unsigned pct);
    for (int i = 0; i < NT; i++) stall_pct[i] = pct;
  endtask

  initial begin
    cycle = 0;
    while (cycle < MAX_CYCLES) begin
      @(posedge clk_i);
      cycle++;
    end
    $display("Run stopped at the limit of %0d cycles", MAX_CYCLES);
    $display("Something failed");
    $finish;
  end

  initial begin
    int err0;
    int lat;
    int prev_tile;
    void'($urandom(32'h9fd502a6));
    errors             = 0;
    tests_failed       = 0;
    yumi_pct           = 100;
    reset_i            = 1'b1;
    global_ctr_clear_i = 1'b0;
    stall_i            = '0;
    stall_depend_i     = '0;
    flush_i            = '0;
    id_instr_i         = '0;
    id_icache_miss_i   = '0;
    req_v_i            = '0;
    req_yumi_i         = '0;
    req_addr_i         = '0;
    req_payload_i      = '0;
    rec_yumi_i         = 1'b0;
    set_stall(20);
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    err0 = errors;
    repeat (20) @(negedge clk_i);
    drive_req(4'b0010, 32'h0000_1D08, 32'hDEAD_0000, '1);  // Wrong address.
    drive_req(4'b0100, `PROF_PRINT_STAT_ADDR, 32'hDEAD_1000, '0);  // Valid only.
    drive_req(4'b1000, 32'h1D0C_0000, 32'hDEAD_2000, '1);
    repeat (30) begin
      @(negedge clk_i);
      assert (!rec_v_o) else begin
        $display("A record appeared although no print was accepted");
        errors++;
      end
    end
    end_test(1, "idle and non-print requests", err0);

    err0 = errors;
    for (int t = 0; t < NT; t++) begin
      set_stall(25);
      repeat (10) @(negedge clk_i);
      set_stall(0);
      repeat (2) @(negedge clk_i);
      measure_print(t, 32'h1000_0000 + 32'(t << 8), lat);
      check("latency", lat, 32'd5);
      wait_drain();
    end
    end_test(2, "single print without stall", err0);

    err0 = errors;
    for (int k = 0; k < 6; k++) begin
      set_stall(20);
      stall_pct[k % NT] = 40;
      measure_print(k % NT, 32'h2000_0000 + 32'(k << 8), lat);
      check("latency", lat, 32'(5 + m_stalls[k % NT]));
      wait_drain();
    end
    end_test(3, "print under stalls", err0);

    err0 = errors;
    set_stall(0);
    yumi_pct = 30;
    prev_tile = taken_q[$];  // Round robin resumes after this tile.
    taken_q.delete();
    for (int r = 0; r < 3; r++) begin
      drive_req('1, `PROF_PRINT_STAT_ADDR, 32'h3000_0000 + 32'(r << 8), '1);
      wait_drain();
    end
    check("record count", 32'(taken_q.size()), 32'd12);
    for (int k = 0; k < taken_q.size(); k++) begin
      check("record tile", 32'(taken_q[k]), 32'((prev_tile + 1) % NT));
      prev_tile = taken_q[k];
    end
    end_test(4, "round-robin under back-pressure", err0);

    err0 = errors;
    yumi_pct = 0;
    @(negedge clk_i);
    global_ctr_clear_i = 1'b1;
    @(negedge clk_i);
    global_ctr_clear_i = 1'b0;
    drive_req(4'b0001, `PROF_PRINT_STAT_ADDR, 32'h5000_0000, '1);
    repeat (8) @(negedge clk_i);  // Tile 0 record now blocks the output.
    drive_req(4'b0100, `PROF_PRINT_STAT_ADDR, 32'h5A00_0000, '1);
    repeat (8) @(negedge clk_i);
    drive_req(4'b0100, `PROF_PRINT_STAT_ADDR, 32'h5B00_0000, '1);
    repeat (8) @(negedge clk_i);
    yumi_pct = 100;
    wait_drain();
    check("rec_tag_o", taken_tag, 32'h5B00_0002);
    check("rec_dropped_o", taken_drop, 32'd1);
    assert (taken_gc < 32'd64) else begin
      $display("Global counter in the record did not restart after the clear");
      errors++;
    end
    end_test(5, "overwrite and counter clear", err0);

    $display("Tests run: 5, tests failed: %0d, failed checks: %0d", tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+rtl
rtl/prof_pkg.sv
rtl/prof_req_decoder.sv
rtl/tile_profiler.sv
rtl/prof_stat_collector.sv
rtl/prof_top.sv
dv/prof_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the profiling testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Mdir obj_dir -f sim.f --top-module prof_tb \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/Vprof_tb > sim.log 2>&1 || echo "Simulation exited with an error status"
cat sim.log
grep -q "Everything OK" sim.log && exit 0 || exit 1
